// File: sim.f
mapper_pkg.sv
slot_decode.sv
mapper_ascii8.sv
mapper_ascii16.sv
mapper_konami.sv
mapper_merge.sv
cart_mappers.sv
tb_cart_mappers.sv

// File: tb_cart_mappers.sv
module tb_cart_mappers;
    timeunit 1ns;
    timeprecision 1ps;

    import mapper_pkg::*;

    localparam int MAX_ENTRIES = 64;
    localparam logic [MEM_AW-1:0] BASE_A8  = 22'h04_0000;  // ROM image of the ASCII8 cart
    localparam logic [MEM_AW-1:0] BASE_A16 = 22'h10_0000;
    localparam logic [MEM_AW-1:0] BASE_KON = 22'h20_0000;
    localparam int RESET_TIMEOUT = 20;                     // Cycles allowed for reset release

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic              slot_sel;
    logic [15:0]       cpu_addr;
    logic [7:0]        cpu_din;
    logic              cpu_wr;
    logic              cpu_rd;
    mapper_t           mapper_sel;
    logic [MEM_AW-1:0] rom_base;
    logic [7:0]        mem_rdata;
    logic [7:0]        cpu_dout;
    logic [MEM_AW-1:0] mem_addr;
    logic              mem_cs;

    // Stimulus table as one array per column
    string             t_name [MAX_ENTRIES];
    mapper_t           t_map  [MAX_ENTRIES];
    logic [MEM_AW-1:0] t_base [MAX_ENTRIES];
    logic              t_slot [MAX_ENTRIES];
    logic              t_wr   [MAX_ENTRIES];  // 1 is a register write, 0 a read
    logic [15:0]       t_addr [MAX_ENTRIES];
    logic [7:0]        t_data [MAX_ENTRIES];
    logic              t_cs   [MAX_ENTRIES];  // Expected mem_cs
    logic [MEM_AW-1:0] t_ea   [MAX_ENTRIES];  // Expected mem_addr, all ones when unselected
    logic [7:0]        t_dout [MAX_ENTRIES];
    int                n_entries = 0;
    int                pass_count = 0;
    int                fail_count = 0;

    cart_mappers i_dut (
        .clk        (clk),
        .reset      (reset),
        .slot_sel   (slot_sel),
        .cpu_addr   (cpu_addr),
        .cpu_din    (cpu_din),
        .cpu_wr     (cpu_wr),
        .cpu_rd     (cpu_rd),
        .mapper_sel (mapper_sel),
        .rom_base   (rom_base),
        .mem_rdata  (mem_rdata),
        .cpu_dout   (cpu_dout),
        .mem_addr   (mem_addr),
        .mem_cs     (mem_cs)
    );

    always #5 clk = ~clk;   // 10 ns period

    // ROM content is the XOR of the three address bytes
    function automatic logic [7:0] rom_byte(logic [MEM_AW-1:0] a);
        return {2'b00, a[21:16]} ^ a[15:8] ^ a[7:0];
    endfunction

    always_comb mem_rdata = rom_byte(mem_addr);  // Same cycle answer

    // Base plus bank times bank size plus offset inside the bank
    function automatic logic [MEM_AW-1:0] bank_addr(logic [MEM_AW-1:0] base, logic [7:0] bank,
                                                    logic [15:0] a, bit wide16);
        if (wide16) begin
            return base + MEM_AW'(bank) * 22'h4000 + MEM_AW'(a[13:0]);
        end
        return base + MEM_AW'(bank) * 22'h2000 + MEM_AW'(a[12:0]);
    endfunction

    task automatic add_entry(string name, mapper_t m, logic [MEM_AW-1:0] base, logic slot,
                             logic wr, logic [15:0] a, logic [7:0] d, logic cs,
                             logic [MEM_AW-1:0] ea);
        t_name[n_entries] = name;
        t_map[n_entries]  = m;
        t_base[n_entries] = base;
        t_slot[n_entries] = slot;
        t_wr[n_entries]   = wr;
        t_addr[n_entries] = a;
        t_data[n_entries] = d;
        t_cs[n_entries]   = cs;
        t_ea[n_entries]   = ea;
        t_dout[n_entries] = cs ? rom_byte(ea) : IDLE_DATA;  // Open bus when unselected
        n_entries++;
    endtask

    // Register writes never select memory
    task automatic bank_write(string name, mapper_t m, logic [MEM_AW-1:0] base, logic slot,
                              logic [15:0] a, logic [7:0] d);
        add_entry(name, m, base, slot, 1'b1, a, d, 1'b0, NO_ADDR);
    endtask

    task automatic read_8k(string name, mapper_t m, logic [MEM_AW-1:0] base,
                           logic [15:0] a, logic [7:0] bank);
        add_entry(name, m, base, 1'b1, 1'b0, a, 8'h00, 1'b1, bank_addr(base, bank, a, 1'b0));
    endtask

    task automatic read_16k(string name, logic [15:0] a, logic [7:0] bank);
        add_entry(name, mapper_ascii16, BASE_A16, 1'b1, 1'b0, a, 8'h00, 1'b1,
                  bank_addr(BASE_A16, bank, a, 1'b1));
    endtask

    task automatic idle_read(string name, mapper_t m, logic slot, logic [15:0] a);
        add_entry(name, m, BASE_A8, slot, 1'b0, a, 8'h00, 1'b0, NO_ADDR);
    endtask

    task automatic build_table();
        read_8k("a8_rst_4000", mapper_ascii8, BASE_A8, 16'h4000, 8'h00);   // Reset defaults
        read_8k("a8_rst_8000", mapper_ascii8, BASE_A8, 16'h8000, 8'h00);
        read_8k("a8_rst_a000", mapper_ascii8, BASE_A8, 16'hA000, 8'h00);
        read_16k("a16_rst_4000", 16'h4000, 8'h00);
        read_16k("a16_rst_8000", 16'h8000, 8'h00);
        read_16k("a16_rst_a000", 16'hA000, 8'h00);
        read_8k("kon_rst_4000", mapper_konami, BASE_KON, 16'h4000, 8'h00);
        read_8k("kon_rst_6000", mapper_konami, BASE_KON, 16'h6000, 8'h01);
        read_8k("kon_rst_8000", mapper_konami, BASE_KON, 16'h8000, 8'h02);
        read_8k("kon_rst_a000", mapper_konami, BASE_KON, 16'hA000, 8'h03);
        // ASCII8 with one register per page
        bank_write("a8_wr_6000", mapper_ascii8, BASE_A8, 1'b1, 16'h6000, 8'h05);
        read_8k("a8_p0_bank5", mapper_ascii8, BASE_A8, 16'h4123, 8'h05);
        read_8k("a8_p1_same", mapper_ascii8, BASE_A8, 16'h6123, 8'h00);
        bank_write("a8_wr_6800", mapper_ascii8, BASE_A8, 1'b1, 16'h6800, 8'h0A);
        read_8k("a8_p1_bank0a", mapper_ascii8, BASE_A8, 16'h6ABC, 8'h0A);
        read_8k("a8_p0_kept", mapper_ascii8, BASE_A8, 16'h5FFF, 8'h05);
        bank_write("a8_wr_7000", mapper_ascii8, BASE_A8, 1'b1, 16'h7000, 8'h11);
        read_8k("a8_p2_bank11", mapper_ascii8, BASE_A8, 16'h9FFF, 8'h11);
        read_8k("a8_p3_same", mapper_ascii8, BASE_A8, 16'hA001, 8'h00);
        bank_write("a8_wr_7fff", mapper_ascii8, BASE_A8, 1'b1, 16'h7FFF, 8'h3C);
        read_8k("a8_p3_bank3c", mapper_ascii8, BASE_A8, 16'hA001, 8'h3C);
        read_8k("a8_p2_kept", mapper_ascii8, BASE_A8, 16'h8000, 8'h11);
        read_8k("a8_p1_kept", mapper_ascii8, BASE_A8, 16'h6000, 8'h0A);
        // ASCII16 halves
        bank_write("a16_wr_6000", mapper_ascii16, BASE_A16, 1'b1, 16'h6000, 8'h03);
        read_16k("a16_lo_bank3", 16'h7FFF, 8'h03);
        read_16k("a16_hi_same", 16'h8000, 8'h00);
        bank_write("a16_wr_7000", mapper_ascii16, BASE_A16, 1'b1, 16'h7000, 8'h07);
        read_16k("a16_hi_bank7", 16'hBFFF, 8'h07);
        read_16k("a16_lo_kept", 16'h5555, 8'h03);
        bank_write("a16_wr_6800", mapper_ascii16, BASE_A16, 1'b1, 16'h6800, 8'h0F);
        read_16k("a16_6800_lo", 16'h4000, 8'h03);  // 6800h is no register
        read_16k("a16_6800_hi", 16'h9234, 8'h07);
        // Konami with page 0 fixed
        bank_write("kon_wr_4000", mapper_konami, BASE_KON, 1'b1, 16'h4000, 8'h09);
        read_8k("kon_p0_fixed", mapper_konami, BASE_KON, 16'h4010, 8'h00);
        bank_write("kon_wr_6000", mapper_konami, BASE_KON, 1'b1, 16'h6000, 8'h04);
        read_8k("kon_p1_bank4", mapper_konami, BASE_KON, 16'h6010, 8'h04);
        bank_write("kon_wr_8000", mapper_konami, BASE_KON, 1'b1, 16'h8000, 8'h06);
        read_8k("kon_p2_bank6", mapper_konami, BASE_KON, 16'h8ABC, 8'h06);
        bank_write("kon_wr_a000", mapper_konami, BASE_KON, 1'b1, 16'hA000, 8'h08);
        read_8k("kon_p3_bank8", mapper_konami, BASE_KON, 16'hBFFF, 8'h08);
        read_8k("kon_p0_still", mapper_konami, BASE_KON, 16'h4000, 8'h00);
        // Idle and outside accesses
        idle_read("idle_slot_low", mapper_ascii8, 1'b0, 16'h4000);
        idle_read("idle_below_win", mapper_ascii8, 1'b1, 16'h3FFF);
        idle_read("idle_above_win", mapper_ascii8, 1'b1, 16'hC000);
        idle_read("idle_no_mapper", mapper_none, 1'b1, 16'h4000);
        bank_write("a8_wr_slot_low", mapper_ascii8, BASE_A8, 1'b0, 16'h6000, 8'h77);
        read_8k("a8_p0_unchanged", mapper_ascii8, BASE_A8, 16'h4000, 8'h05);
    endtask

    // Outputs sampled mid cycle once the combinational path has settled
    task automatic check_entry(int i);
        bit ok;
        ok = 1'b1;
        if (mem_cs !== t_cs[i]) begin
            $display("Error %s: mem_cs expected %0b actual %0b", t_name[i], t_cs[i], mem_cs);
            ok = 1'b0;
        end
        if (mem_addr !== t_ea[i]) begin
            $display("Error %s: mem_addr expected %h actual %h", t_name[i], t_ea[i], mem_addr);
            ok = 1'b0;
        end
        if (cpu_dout !== t_dout[i]) begin
            $display("Error %s: cpu_dout expected %h actual %h", t_name[i], t_dout[i], cpu_dout);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("ok    %s", t_name[i]);
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

    initial begin
        int cycles;
        slot_sel   = 1'b0;
        cpu_addr   = '0;
        cpu_din    = '0;
        cpu_wr     = 1'b0;
        cpu_rd     = 1'b0;
        mapper_sel = mapper_none;
        rom_base   = '0;
        cycles     = 0;
        build_table();
        while (reset && (cycles < RESET_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            $display("Reset was never released, run stopped");
            $display("Testbench failed");
            $finish;
        end else begin
            for (int i = 0; i < n_entries; i++) begin
                @(posedge clk);
                mapper_sel <= t_map[i];
                rom_base   <= t_base[i];
                slot_sel   <= t_slot[i];
                cpu_addr   <= t_addr[i];
                cpu_din    <= t_data[i];
                cpu_wr     <= t_wr[i];
                cpu_rd     <= !t_wr[i];  // Read and write never together
                @(negedge clk);
                check_entry(i);
            end
            @(posedge clk);
            cpu_wr <= 1'b0;
            cpu_rd <= 1'b0;
            $display("%0d tests, %0d passed, %0d failed", n_entries, pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

// File: cart_mappers.sv
module cart_mappers (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          slot_sel,
    input  logic [mapper_pkg::CPU_AW-1:0] cpu_addr,
    input  logic [mapper_pkg::CPU_DW-1:0] cpu_din,
    input  logic                          cpu_wr,
    input  logic                          cpu_rd,
    input  mapper_pkg::mapper_t           mapper_sel,  // Cartridge mapper kind
    input  logic [mapper_pkg::MEM_AW-1:0] rom_base,    // ROM image start
    input  logic [mapper_pkg::CPU_DW-1:0] mem_rdata,
    output logic [mapper_pkg::CPU_DW-1:0] cpu_dout,
    output logic [mapper_pkg::MEM_AW-1:0] mem_addr,
    output logic                          mem_cs
);
    import mapper_pkg::*;

    // Decode to mappers
    logic              en_ascii8;
    logic              en_ascii16;
    logic              en_konami;
    logic              win_rd;
    logic              win_wr;
    logic [PAGE_W-1:0] page;

    // Mappers to merge
    logic [MEM_AW-1:0] addr_ascii8;
    logic [MEM_AW-1:0] addr_ascii16;
    logic [MEM_AW-1:0] addr_konami;
    logic              cs_ascii8;
    logic              cs_ascii16;
    logic              cs_konami;

    slot_decode i_decode (
        .slot_sel   (slot_sel),
        .cpu_addr   (cpu_addr),
        .cpu_wr     (cpu_wr),
        .cpu_rd     (cpu_rd),
        .mapper_sel (mapper_sel),
        .en_ascii8  (en_ascii8),
        .en_ascii16 (en_ascii16),
        .en_konami  (en_konami),
        .win_rd     (win_rd),
        .win_wr     (win_wr),
        .page       (page)
    );

    mapper_ascii8 i_ascii8 (
        .clk      (clk),
        .reset    (reset),
        .en       (en_ascii8),
        .win_rd   (win_rd),
        .win_wr   (win_wr),
        .page     (page),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .rom_base (rom_base),
        .mem_addr (addr_ascii8),
        .mem_cs   (cs_ascii8)
    );

    mapper_ascii16 i_ascii16 (
        .clk      (clk),
        .reset    (reset),
        .en       (en_ascii16),
        .win_rd   (win_rd),
        .win_wr   (win_wr),
        .page     (page),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .rom_base (rom_base),
        .mem_addr (addr_ascii16),
        .mem_cs   (cs_ascii16)
    );

    mapper_konami i_konami (
        .clk      (clk),
        .reset    (reset),
        .en       (en_konami),
        .win_rd   (win_rd),
        .win_wr   (win_wr),
        .page     (page),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .rom_base (rom_base),
        .mem_addr (addr_konami),
        .mem_cs   (cs_konami)
    );

    // AND of addresses, OR of selects
    mapper_merge i_merge (
        .addr_ascii8  (addr_ascii8),
        .addr_ascii16 (addr_ascii16),
        .addr_konami  (addr_konami),
        .cs_ascii8    (cs_ascii8),
        .cs_ascii16   (cs_ascii16),
        .cs_konami    (cs_konami),
        .mem_rdata    (mem_rdata),
        .mem_addr     (mem_addr),
        .mem_cs       (mem_cs),
        .cpu_dout     (cpu_dout)
    );

endmodule

// File: mapper_merge.sv
module mapper_merge (
    input  logic [mapper_pkg::MEM_AW-1:0] addr_ascii8,
    input  logic [mapper_pkg::MEM_AW-1:0] addr_ascii16,
    input  logic [mapper_pkg::MEM_AW-1:0] addr_konami,
    input  logic                          cs_ascii8,
    input  logic                          cs_ascii16,
    input  logic                          cs_konami,
    input  logic [mapper_pkg::CPU_DW-1:0] mem_rdata,   // Same cycle ROM data
    output logic [mapper_pkg::MEM_AW-1:0] mem_addr,
    output logic                          mem_cs,
    output logic [mapper_pkg::CPU_DW-1:0] cpu_dout
);
    import mapper_pkg::*;

    // Idle mappers drive all ones, so only the active one shows through
    assign mem_addr = addr_ascii8 & addr_ascii16 & addr_konami;

    // At most one mapper selects at a time
    assign mem_cs = cs_ascii8 | cs_ascii16 | cs_konami;

    // Open bus reads back FFh
    assign cpu_dout = mem_cs ? mem_rdata : IDLE_DATA;

endmodule

// File: mapper_konami.sv
module mapper_konami (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          en,        // Konami is the active mapper
    input  logic                          win_rd,
    input  logic                          win_wr,
    input  logic [mapper_pkg::PAGE_W-1:0] page,
    input  logic [mapper_pkg::CPU_AW-1:0] cpu_addr,
    input  logic [mapper_pkg::CPU_DW-1:0] cpu_din,
    input  logic [mapper_pkg::MEM_AW-1:0] rom_base,
    output logic [mapper_pkg::MEM_AW-1:0] mem_addr,
    output logic                          mem_cs
);
    import mapper_pkg::*;

    logic [BANK_W-1:0] bank [1:3];  // Switchable pages only
    logic [BANK_W-1:0] cur_bank;    // Bank of the page being read
    logic [MEM_AW-1:0] bank_ofs;

    // A write anywhere in page 1..3 loads that page's bank
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 4; i++) begin
                bank[i] <= KONAMI_RESET_BANKS[i];
            end
        end else if (en && win_wr && (page != '0)) begin
            bank[page] <= cpu_din;
        end
    end

    // Page 0 at 4000h is hardwired to bank 0
    assign cur_bank = (page == '0) ? KONAMI_RESET_BANKS[0] : bank[page];
    assign bank_ofs = MEM_AW'(cur_bank) << OFS8_W;

    always_comb begin
        if (en && win_rd) begin
            mem_addr = rom_base + bank_ofs + MEM_AW'(cpu_addr[OFS8_W-1:0]);
            mem_cs   = 1'b1;
        end else begin
            mem_addr = NO_ADDR;
            mem_cs   = 1'b0;
        end
    end

endmodule

// File: mapper_ascii16.sv
module mapper_ascii16 (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          en,        // ASCII16 is the active mapper
    input  logic                          win_rd,
    input  logic                          win_wr,
    input  logic [mapper_pkg::PAGE_W-1:0] page,      // Bit 1 picks the 16 KB half
    input  logic [mapper_pkg::CPU_AW-1:0] cpu_addr,
    input  logic [mapper_pkg::CPU_DW-1:0] cpu_din,
    input  logic [mapper_pkg::MEM_AW-1:0] rom_base,
    output logic [mapper_pkg::MEM_AW-1:0] mem_addr,
    output logic                          mem_cs
);
    import mapper_pkg::*;

    logic [BANK_W-1:0] bank [2];    // 0 serves 4000h..7FFFh, 1 serves 8000h..BFFFh
    logic [MEM_AW-1:0] bank_ofs;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank[0] <= '0;
            bank[1] <= '0;
        end else if (en && win_wr) begin
            // 6800h and 7800h ranges are ignored
            if (cpu_addr[15:11] == 5'b01100) begin
                bank[0] <= cpu_din;             // 6000h..67FFh
            end
            if (cpu_addr[15:11] == 5'b01110) begin
                bank[1] <= cpu_din;             // 7000h..77FFh
            end
        end
    end

    assign bank_ofs = MEM_AW'(bank[page[PAGE_W-1]]) << OFS16_W;

    always_comb begin
        if (en && win_rd) begin
            mem_addr = rom_base + bank_ofs + MEM_AW'(cpu_addr[OFS16_W-1:0]);
            mem_cs   = 1'b1;
        end else begin
            mem_addr = NO_ADDR;                 // Inactive, all ones
            mem_cs   = 1'b0;
        end
    end

endmodule

// File: mapper_ascii8.sv
module mapper_ascii8 (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          en,        // ASCII8 is the active mapper
    input  logic                          win_rd,
    input  logic                          win_wr,
    input  logic [mapper_pkg::PAGE_W-1:0] page,
    input  logic [mapper_pkg::CPU_AW-1:0] cpu_addr,
    input  logic [mapper_pkg::CPU_DW-1:0] cpu_din,
    input  logic [mapper_pkg::MEM_AW-1:0] rom_base,  // ROM image start
    output logic [mapper_pkg::MEM_AW-1:0] mem_addr,
    output logic                          mem_cs
);
    import mapper_pkg::*;

    logic [BANK_W-1:0] bank [4];    // One bank per 8 KB page
    logic [MEM_AW-1:0] bank_ofs;    // Bank start inside the ROM image
    logic              reg_hit;     // Write to 6000h..7FFFh

    // Registers at 6000h, 6800h, 7000h and 7800h, 2 KB each
    assign reg_hit = en && win_wr && (cpu_addr[15:13] == 3'b011);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= '0;
            end
        end else if (reg_hit) begin
            bank[cpu_addr[12:11]] <= cpu_din;   // Bits 12:11 pick the register
        end
    end

    assign bank_ofs = MEM_AW'(bank[page]) << OFS8_W;

    // Translation, idle value keeps the AND merge neutral
    always_comb begin
        if (en && win_rd) begin
            mem_addr = rom_base + bank_ofs + MEM_AW'(cpu_addr[OFS8_W-1:0]);
            mem_cs   = 1'b1;
        end else begin
            mem_addr = NO_ADDR;
            mem_cs   = 1'b0;
        end
    end

endmodule

// File: slot_decode.sv
module slot_decode (
    input  logic                         slot_sel,    // Cartridge slot is addressed
    input  logic [mapper_pkg::CPU_AW-1:0] cpu_addr,
    input  logic                         cpu_wr,      // One cycle write strobe
    input  logic                         cpu_rd,      // One cycle read strobe
    input  mapper_pkg::mapper_t          mapper_sel,  // Static cartridge config
    output logic                         en_ascii8,
    output logic                         en_ascii16,
    output logic                         en_konami,
    output logic                         win_rd,      // Read inside the window
    output logic                         win_wr,      // Write inside the window
    output logic [mapper_pkg::PAGE_W-1:0] page        // 8 KB page index, 0 is 4000h
);
    import mapper_pkg::*;

    logic [2:0] page8;      // Raw 8 KB page of the CPU address
    logic [2:0] page_rel;   // Page relative to window start
    logic       in_win;     // Slot hit and address in 4000h..BFFFh

    assign page8    = cpu_addr[CPU_AW-1:CPU_AW-3];
    assign page_rel = page8 - WIN_FIRST;

    // Slot and window tested once here for all mappers
    assign in_win = slot_sel && (page8 >= WIN_FIRST) && (page8 <= WIN_LAST);

    assign win_rd = cpu_rd && in_win;
    assign win_wr = cpu_wr && in_win;   // Register write anywhere in the window
    assign page   = page_rel[PAGE_W-1:0];

    // One-hot mapper enables
    always_comb begin
        en_ascii8  = 1'b0;
        en_ascii16 = 1'b0;
        en_konami  = 1'b0;
        case (mapper_sel)
            mapper_ascii8:  en_ascii8  = 1'b1;
            mapper_ascii16: en_ascii16 = 1'b1;
            mapper_konami:  en_konami  = 1'b1;
            default: ;                      // mapper_none, nobody answers
        endcase
    end

endmodule

// File: mapper_pkg.sv
package mapper_pkg;

    // Mapper kinds selected by the cartridge block configuration
    typedef enum logic [2:0] {
        mapper_none    = 3'd0,  // Nothing answers in the window
        mapper_ascii8  = 3'd1,  // Four 8 KB banks
        mapper_ascii16 = 3'd2,  // Two 16 KB banks
        mapper_konami  = 3'd3   // Konami without SCC
    } mapper_t;

    // CPU bus sizes
    localparam int CPU_AW = 16;                 // Z80 address width
    localparam int CPU_DW = 8;                  // Z80 data width

    // External memory side
    localparam int MEM_AW = 22;                 // 4 MB of ROM space

    // Bank registers and cartridge window
    localparam int BANK_W = 8;                  // One byte per bank register
    localparam int PAGE_W = 2;                  // Four 8 KB pages from 4000h to BFFFh
    localparam int OFS8_W = 13;                 // Offset inside an 8 KB bank
    localparam int OFS16_W = 14;                // Offset inside a 16 KB bank

    // Window in units of 8 KB, taken from cpu_addr[15:13]
    localparam logic [2:0] WIN_FIRST = 3'd2;    // 4000h
    localparam logic [2:0] WIN_LAST = 3'd5;     // A000h, last page before C000h

    // Merge values for inactive sources
    localparam logic [MEM_AW-1:0] NO_ADDR = '1;         // Neutral for the AND merge
    localparam logic [CPU_DW-1:0] IDLE_DATA = 8'hFF;    // Open bus byte

    // Konami banks after reset, index is the page
    localparam logic [3:0][BANK_W-1:0] KONAMI_RESET_BANKS = {
        8'd3,   // Page 3, A000h
        8'd2,   // Page 2, 8000h
        8'd1,   // Page 1, 6000h
        8'd0    // Page 0, 4000h, never changes
    };

endpackage
